// File: flist.f
design/rvPkg.sv
design/fetchStage.sv
design/hazardDetection.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/rvCore.sv
testbench/rvCore_assert.sv
testbench/rvCoreTb.sv

// File: Makefile
# Verilator build and run for the RV32I subset core
TOP = rvCoreTb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/rvCoreTb.sv
// ################################################
// directed tests for the RV32I subset core
// each test loads its program while in reset and
// compares retire and store events in order
// programs write a register before reading it, as
// the register file has no reset
// ################################################
`timescale 1ns/1ps
module rvCoreTb;

	// five tests of roughly 20 load cycles and 40 run cycles each, doubled for
	// worst case stalls and then given a wide margin
	localparam int cycleLimit = 2000;
	// major opcodes for ADDI and LW
	localparam int immOp = 'h13;
	localparam int loadOp = 'h03;
	localparam logic [31:0] ecallWord = 32'h0000_0073;

	logic clk;
	logic rstN;
	logic imemWe;
	logic [7:0] imemAddr;
	logic [31:0] imemData;
	logic retireValid;
	logic [4:0] retireRd;
	logic [31:0] retireData;
	logic storeValid;
	logic [31:0] storeAddr;
	logic [31:0] storeData;
	logic halted;

	int seed = 60454;
	int cycles = 0;
	string testName;
	logic [31:0] model [32];
	logic [31:0] prog [$];
	// retire events are {rd, data} and store events are {addr, data}
	logic [36:0] expRet [$];
	logic [36:0] gotRet [$];
	logic [63:0] expSt [$];
	logic [63:0] gotSt [$];

	rvCore #(.imemDepth(64), .dmemDepth(64)) dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			failRun("timeout: the run went past the cycle limit without finishing");
		end
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			failRun($sformatf("Mismatch %s in %s test: got 0x%08h, expected 0x%08h",
				name, testName, got, want));
		end
	endtask

	// instruction encoders straight from the RV32I formats
	function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1, input int f3,
		input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(input int imm, input int rs1, input int f3, input int rd,
		input int op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	// the model register takes the value and the retire stream expects it next
	task automatic expectWrite(input int rd, input logic [31:0] value);
		model[rd] = value;
		expRet.push_back({rd[4:0], value});
	endtask

	task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
		expSt.push_back({addr, data});
	endtask

	task automatic startTest(input string name);
		testName = name;
		prog.delete();
		expRet.delete();
		gotRet.delete();
		expSt.delete();
		gotSt.delete();
	endtask

	// loads the program in reset, then records events until halted and five quiet cycles
	task automatic runProgram();
		int quiet;
		logic sawHalt;
		quiet = 0;
		sawHalt = 1'b0;
		@(posedge clk);
		#1;
		rstN = 1'b0;
		for (int idx = 0; idx < prog.size(); idx++) begin
			imemWe = 1'b1;
			imemAddr = 8'(idx);
			imemData = prog[idx];
			@(posedge clk);
			#1;
		end
		imemWe = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rstN = 1'b1;
		while (quiet < 5) begin
			@(negedge clk);
			if (dut0.assert0.flushFails + dut0.assert0.stallFails +
				dut0.assert0.drainFails != 0) begin
				failRun($sformatf("a bound assertion failed during the %s test", testName));
			end
			if (retireValid) begin
				gotRet.push_back({retireRd, retireData});
			end
			if (storeValid) begin
				gotSt.push_back({storeAddr, storeData});
			end
			if (sawHalt && !halted) begin
				failRun($sformatf("halted dropped again in the %s test", testName));
			end
			if (halted) begin
				sawHalt = 1'b1;
			end
			if (sawHalt && !retireValid && !storeValid) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
	endtask

	// equal counts also show that nothing from a wrong path or past ECALL came out
	task automatic compareResults();
		checkValue("retire count", 32'(gotRet.size()), 32'(expRet.size()));
		foreach (expRet[i]) begin
			checkValue("retireRd", 32'(gotRet[i][36:32]), 32'(expRet[i][36:32]));
			checkValue("retireData", gotRet[i][31:0], expRet[i][31:0]);
		end
		checkValue("store count", 32'(gotSt.size()), 32'(expSt.size()));
		foreach (expSt[i]) begin
			checkValue("storeAddr", gotSt[i][63:32], expSt[i][63:32]);
			checkValue("storeData", gotSt[i][31:0], expSt[i][31:0]);
		end
		checkValue("halted", 32'(halted), 32'd1);
	endtask

	// each result is read one, two and three slots later
	task automatic testForwarding();
		int a;
		int b;
		startTest("forwarding");
		a = $random(seed) % 2048;
		b = $random(seed) % 2048;
		emit(encI(a, 0, 0, 1, immOp));
		expectWrite(1, a);
		emit(encI(b, 1, 0, 2, immOp));
		expectWrite(2, model[1] + b);
		emit(encR(0, 2, 1, 0, 3));
		expectWrite(3, model[1] + model[2]);
		emit(encR(32, 1, 3, 0, 4));
		expectWrite(4, model[3] - model[1]);
		emit(encR(0, 2, 4, 7, 5));
		expectWrite(5, model[4] & model[2]);
		emit(encR(0, 3, 5, 6, 6));
		expectWrite(6, model[5] | model[3]);
		emit(ecallWord);
		runProgram();
		compareResults();
	endtask

	task automatic testLoadUse();
		int v;
		startTest("load-to-use");
		v = $random(seed) % 2048;
		emit(encI(64, 0, 0, 1, immOp));
		expectWrite(1, 64);
		emit(encI(v, 0, 0, 2, immOp));
		expectWrite(2, v);
		emit(encS(8, 2, 1));
		expectStore(model[1] + 8, model[2]);
		emit(encI(8, 1, 2, 3, loadOp));
		expectWrite(3, model[2]);
		// the ADD needs the loaded word in the very next slot
		emit(encR(0, 1, 3, 0, 4));
		expectWrite(4, model[3] + model[1]);
		emit(ecallWord);
		runProgram();
		compareResults();
	endtask

	// every branch skips one instruction, which only retires when the model says not taken
	task automatic testBranchHazards();
		startTest("branch hazard");
		emit(encI(5, 0, 0, 1, immOp));
		expectWrite(1, 5);
		emit(encI(5, 0, 0, 2, immOp));
		expectWrite(2, 5);
		emit(encB(8, 2, 1, 0));
		emit(encI(99, 0, 0, 3, immOp));
		if (model[1] != model[2]) begin
			expectWrite(3, 99);
		end
		emit(encI(7, 0, 0, 4, immOp));
		expectWrite(4, 7);
		emit(encS(0, 4, 0));
		expectStore(32'd0, model[4]);
		emit(encI(0, 0, 2, 5, loadOp));
		expectWrite(5, model[4]);
		emit(encB(8, 4, 5, 1));
		emit(encI(1, 0, 0, 6, immOp));
		if (model[5] == model[4]) begin
			expectWrite(6, 1);
		end
		emit(encI(0, 0, 2, 7, loadOp));
		expectWrite(7, model[4]);
		emit(encB(8, 1, 7, 1));
		emit(encI(55, 0, 0, 8, immOp));
		if (model[7] == model[1]) begin
			expectWrite(8, 55);
		end
		emit(ecallWord);
		runProgram();
		compareResults();
	endtask

	task automatic testLoops();
		int n;
		logic [31:0] link;
		startTest("loop");
		n = 3 + ($random(seed) & 3);
		emit(encI(0, 0, 0, 1, immOp));
		expectWrite(1, 0);
		emit(encI(n, 0, 0, 2, immOp));
		expectWrite(2, n);
		// counted loop body at byte address 8, closed by a BNE back by one word
		emit(encI(1, 1, 0, 1, immOp));
		emit(encB(-4, 2, 1, 1));
		do begin
			expectWrite(1, model[1] + 1);
		end while (model[1] != model[2]);
		link = 32'(4 * prog.size() + 4);
		emit(encJ(8, 5));
		expectWrite(5, link);
		emit(encI(77, 0, 0, 6, immOp));
		emit(encR(0, 1, 5, 0, 7));
		expectWrite(7, model[5] + model[1]);
		emit(ecallWord);
		runProgram();
		compareResults();
	endtask

	// the words after ECALL must neither retire nor store
	task automatic testHalt();
		startTest("halt");
		emit(encI(3, 0, 0, 1, immOp));
		expectWrite(1, 3);
		emit(ecallWord);
		emit(encI(9, 0, 0, 2, immOp));
		emit(encS(4, 1, 0));
		emit(encI(10, 0, 0, 3, immOp));
		runProgram();
		compareResults();
	endtask

	initial begin
		rstN = 1'b0;
		imemWe = 1'b0;
		imemAddr = 8'h00;
		imemData = 32'h0;
		testForwarding();
		testLoadUse();
		testBranchHazards();
		testLoops();
		testHalt();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: testbench/rvCore_assert.sv
// ################################################
// assertions on how fetch answers the hazard
// control, and on the retire port after a halt
// bound into the core top level
// each failure is also counted for the testbench
// ################################################
`timescale 1ns/1ps
module hazardAssert (
	input logic                   clk,
	input logic                   rstN,
	input logic                   fdHold,
	input logic                   redirect,
	input logic                   halted,
	input logic                   retireValid,
	input logic [rvPkg::xlen-1:0] fdInstr,
	input logic [rvPkg::xlen-1:0] fdPc
);

	int flushFails = 0;
	int stallFails = 0;
	int drainFails = 0;
	int drained;

	// retirements seen while halted, which can only come from instructions already in flight
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			drained <= 0;
		end else if (halted && retireValid) begin
			drained <= drained + 1;
		end
	end

	// a redirect drops the word fetched down the wrong path
	redirectFlushes: assert property (@(posedge clk) disable iff (!rstN)
		redirect |=> fdInstr == rvPkg::nopInstr)
	else begin
		flushFails++;
		$error("redirect did not flush the fetch/decode register");
	end

	// a stall keeps the waiting instruction and its PC in decode
	stallHoldsFetch: assert property (@(posedge clk) disable iff (!rstN)
		fdHold |=> $stable(fdInstr) && $stable(fdPc))
	else begin
		stallFails++;
		$error("fetch/decode changed while held by a stall");
	end

	// at most four instructions sit ahead of decode when halted rises
	drainBounded: assert property (@(posedge clk) disable iff (!rstN) drained <= 4)
	else begin
		drainFails++;
		$error("too many retirements after halt");
	end

endmodule

bind rvCore hazardAssert assert0 (
	.clk,
	.rstN,
	.fdHold,
	.redirect,
	.halted,
	.retireValid,
	.fdInstr,
	.fdPc
);

// File: design/rvCore.sv
// ################################################
// five-stage RV32I subset core, top level
// load the program through imemWe while in reset
// results are seen on the retire and store ports
// ################################################
`timescale 1ns/1ps
module rvCore #(
	parameter int imemDepth = 64,
	parameter int dmemDepth = 64
) (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      imemWe,
	input  logic [7:0]                imemAddr,
	input  logic [rvPkg::xlen-1:0]    imemData,
	output logic                      retireValid,
	output logic [rvPkg::regBits-1:0] retireRd,
	output logic [rvPkg::xlen-1:0]    retireData,
	output logic                      storeValid,
	output logic [rvPkg::xlen-1:0]    storeAddr,
	output logic [rvPkg::xlen-1:0]    storeData,
	output logic                      halted
);

	// hazard control
	logic pcEnable;
	logic fdFlush;
	logic fdHold;
	logic deBubble;
	logic redirect;
	logic takeBranch;
	logic isControl;
	logic [rvPkg::xlen-1:0] branchTarget;

	// fetch/decode
	logic [rvPkg::xlen-1:0] fdInstr;
	logic [rvPkg::xlen-1:0] fdPc;

	// decode/execute
	logic [rvPkg::xlen-1:0] deInstr;
	logic deRegWrite;
	logic deMemRead;
	logic deMemWrite;
	logic deIsLink;
	logic [rvPkg::xlen-1:0] deRs1Val;
	logic [rvPkg::xlen-1:0] deRs2Val;
	logic [rvPkg::xlen-1:0] deImm;
	logic [rvPkg::xlen-1:0] deLink;
	rvPkg::aluOpE deAluOp;
	logic [rvPkg::regBits-1:0] deRd;
	logic [rvPkg::regBits-1:0] deRs1;
	logic [rvPkg::regBits-1:0] deRs2;

	// execute/memory
	logic [rvPkg::xlen-1:0] emAluResult;
	logic [rvPkg::xlen-1:0] emStoreData;
	logic [rvPkg::regBits-1:0] emRd;
	logic emRegWrite;
	logic emMemRead;
	logic emMemWrite;
	logic [rvPkg::xlen-1:0] emInstr;

	// memory/writeback
	logic wbRegWrite;
	logic [rvPkg::regBits-1:0] wbRd;
	logic [rvPkg::xlen-1:0] wbData;

	// every stage port has the same name as the signal it connects to
	fetchStage #(.imemDepth(imemDepth)) fetch0 (.*);
	decodeStage decode0 (.*);
	executeStage execute0 (.*);
	memoryStage #(.dmemDepth(dmemDepth)) memory0 (.*);
	hazardDetection hazard0 (.*);

	// writes to x0 carry no result and are not reported
	assign retireValid = wbRegWrite && wbRd != '0;
	assign retireRd = wbRd;
	assign retireData = wbData;

endmodule

// File: design/memoryStage.sv
// ################################################
// data memory, store port and the memory/writeback
// register
// word accesses only, the address wraps modulo
// dmemDepth, which must be a power of two
// ################################################
`timescale 1ns/1ps
module memoryStage #(
	parameter int dmemDepth = 64
) (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic [rvPkg::xlen-1:0]    emAluResult,
	input  logic [rvPkg::xlen-1:0]    emStoreData,
	input  logic [rvPkg::regBits-1:0] emRd,
	input  logic                      emRegWrite,
	input  logic                      emMemRead,
	input  logic                      emMemWrite,
	output logic                      wbRegWrite,
	output logic [rvPkg::regBits-1:0] wbRd,
	output logic [rvPkg::xlen-1:0]    wbData,
	output logic                      storeValid,
	output logic [rvPkg::xlen-1:0]    storeAddr,
	output logic [rvPkg::xlen-1:0]    storeData
);

	localparam int idxBits = $clog2(dmemDepth);

	logic [rvPkg::xlen-1:0] dmem [dmemDepth];
	logic [idxBits-1:0] idx;

	// byte address in, word index out
	assign idx = emAluResult[2 +: idxBits];

	always_ff @(posedge clk) begin
		if (emMemWrite) begin
			dmem[idx] <= emStoreData;
		end
	end

	// stores show up here one cycle before their retire slot
	assign storeValid = emMemWrite;
	assign storeAddr = emAluResult;
	assign storeData = emStoreData;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbRegWrite <= 1'b0;
		end else begin
			wbRegWrite <= emRegWrite;
		end
	end

	always_ff @(posedge clk) begin
		wbRd <= emRd;
		wbData <= emMemRead ? dmem[idx] : emAluResult;
	end

endmodule

// File: design/executeStage.sv
// ################################################
// operand forwarding, ALU and the execute/memory
// register
// forwards from execute/memory and memory/writeback
// a load one stage ahead is never forwarded, the
// hazard block has already stalled that case
// ################################################
`timescale 1ns/1ps
module executeStage (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic [rvPkg::xlen-1:0]    deInstr,
	input  logic                      deRegWrite,
	input  logic                      deMemRead,
	input  logic                      deMemWrite,
	input  logic                      deIsLink,
	input  logic [rvPkg::xlen-1:0]    deRs1Val,
	input  logic [rvPkg::xlen-1:0]    deRs2Val,
	input  logic [rvPkg::xlen-1:0]    deImm,
	input  logic [rvPkg::xlen-1:0]    deLink,
	input  rvPkg::aluOpE              deAluOp,
	input  logic [rvPkg::regBits-1:0] deRd,
	input  logic [rvPkg::regBits-1:0] deRs1,
	input  logic [rvPkg::regBits-1:0] deRs2,
	input  logic                      wbRegWrite,
	input  logic [rvPkg::regBits-1:0] wbRd,
	input  logic [rvPkg::xlen-1:0]    wbData,
	output logic [rvPkg::xlen-1:0]    emAluResult,
	output logic [rvPkg::xlen-1:0]    emStoreData,
	output logic [rvPkg::regBits-1:0] emRd,
	output logic                      emRegWrite,
	output logic                      emMemRead,
	output logic                      emMemWrite,
	output logic [rvPkg::xlen-1:0]    emInstr
);

	logic emFwd;
	logic wbFwd;
	logic [rvPkg::xlen-1:0] opA;
	logic [rvPkg::xlen-1:0] opB;
	logic [rvPkg::xlen-1:0] rs2Fwd;
	logic [rvPkg::xlen-1:0] aluOut;

	assign emFwd = emRegWrite && !emMemRead && emRd != '0;
	assign wbFwd = wbRegWrite && wbRd != '0;

	// the nearer stage holds the newer value and is checked first
	always_comb begin
		opA = deRs1Val;
		if (emFwd && emRd == deRs1) opA = emAluResult;
		else if (wbFwd && wbRd == deRs1) opA = wbData;
		rs2Fwd = deRs2Val;
		if (emFwd && emRd == deRs2) rs2Fwd = emAluResult;
		else if (wbFwd && wbRd == deRs2) rs2Fwd = wbData;
	end

	// only the register format takes its second operand from rs2
	assign opB = (rvPkg::opcodeE'(deInstr[6:0]) == rvPkg::opReg) ? rs2Fwd : deImm;

	always_comb begin
		case (deAluOp)
			rvPkg::aluSub: aluOut = opA - opB;
			rvPkg::aluAnd: aluOut = opA & opB;
			rvPkg::aluOr: aluOut = opA | opB;
			default: aluOut = opA + opB;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			emInstr <= rvPkg::nopInstr;
			emRegWrite <= 1'b0;
			emMemRead <= 1'b0;
			emMemWrite <= 1'b0;
		end else begin
			emInstr <= deInstr;
			emRegWrite <= deRegWrite;
			emMemRead <= deMemRead;
			emMemWrite <= deMemWrite;
		end
	end

	// JAL writes its return address instead of the ALU output
	always_ff @(posedge clk) begin
		emAluResult <= deIsLink ? deLink : aluOut;
		emStoreData <= rs2Fwd;
		emRd <= deRd;
	end

endmodule

// File: design/decodeStage.sv
// ################################################
// register file, decode, immediates, branch
// resolution and the decode/execute register
// x0 reads as zero, writeback bypasses the file
// only BEQ and BNE are told apart by funct3
// ################################################
`timescale 1ns/1ps
module decodeStage (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic [rvPkg::xlen-1:0]    fdInstr,
	input  logic [rvPkg::xlen-1:0]    fdPc,
	input  logic                      deBubble,
	input  logic                      wbRegWrite,
	input  logic [rvPkg::regBits-1:0] wbRd,
	input  logic [rvPkg::xlen-1:0]    wbData,
	input  logic [rvPkg::xlen-1:0]    emAluResult,
	input  logic                      emRegWrite,
	input  logic [rvPkg::regBits-1:0] emRd,
	output logic                      takeBranch,
	output logic                      isControl,
	output logic [rvPkg::xlen-1:0]    branchTarget,
	output logic [rvPkg::xlen-1:0]    deInstr,
	output logic                      deRegWrite,
	output logic                      deMemRead,
	output logic [rvPkg::xlen-1:0]    deRs1Val,
	output logic [rvPkg::xlen-1:0]    deRs2Val,
	output logic [rvPkg::xlen-1:0]    deImm,
	output rvPkg::aluOpE              deAluOp,
	output logic [rvPkg::regBits-1:0] deRd,
	output logic                      deMemWrite,
	output logic                      deIsLink,
	output logic [rvPkg::xlen-1:0]    deLink,
	output logic [rvPkg::regBits-1:0] deRs1,
	output logic [rvPkg::regBits-1:0] deRs2
);

	logic [rvPkg::xlen-1:0] regs [32];
	rvPkg::opcodeE op;
	rvPkg::aluOpE aluOp;
	logic [2:0] funct3;
	logic [rvPkg::regBits-1:0] rs1;
	logic [rvPkg::regBits-1:0] rs2;
	logic [rvPkg::xlen-1:0] rs1Val;
	logic [rvPkg::xlen-1:0] rs2Val;
	logic [rvPkg::xlen-1:0] cmpA;
	logic [rvPkg::xlen-1:0] cmpB;
	logic [rvPkg::xlen-1:0] immI;
	logic [rvPkg::xlen-1:0] immS;
	logic [rvPkg::xlen-1:0] immB;
	logic [rvPkg::xlen-1:0] immJ;
	logic isBranch;
	logic isJal;

	// picks a newer value over the stored one when the index matches
	function automatic logic [rvPkg::xlen-1:0] bypass(
		input logic [rvPkg::regBits-1:0] idx,
		input logic [rvPkg::xlen-1:0] stored,
		input logic newEn,
		input logic [rvPkg::regBits-1:0] newRd,
		input logic [rvPkg::xlen-1:0] newVal
	);
		if (idx == '0) return '0;
		if (newEn && newRd == idx) return newVal;
		return stored;
	endfunction

	assign op = rvPkg::opcodeE'(fdInstr[6:0]);
	assign funct3 = fdInstr[rvPkg::funct3Lsb +: 3];
	assign rs1 = fdInstr[rvPkg::rs1Lsb +: rvPkg::regBits];
	assign rs2 = fdInstr[rvPkg::rs2Lsb +: rvPkg::regBits];
	assign isBranch = (op == rvPkg::opBranch);
	assign isJal = (op == rvPkg::opJal);
	assign isControl = isBranch || isJal;

	always_ff @(posedge clk) begin
		if (wbRegWrite && wbRd != '0) begin
			regs[wbRd] <= wbData;
		end
	end

	// write before read, so a writeback in this cycle is seen here
	assign rs1Val = bypass(rs1, regs[rs1], wbRegWrite, wbRd, wbData);
	assign rs2Val = bypass(rs2, regs[rs2], wbRegWrite, wbRd, wbData);

	// the branch also sees the ALU result sitting in execute/memory
	// loads there are stalled by the hazard block, so emAluResult is never an address here
	assign cmpA = bypass(rs1, rs1Val, emRegWrite, emRd, emAluResult);
	assign cmpB = bypass(rs2, rs2Val, emRegWrite, emRd, emAluResult);

	assign immI = {{20{fdInstr[31]}}, fdInstr[31:20]};
	assign immS = {{20{fdInstr[31]}}, fdInstr[31:25], fdInstr[11:7]};
	assign immB = {{19{fdInstr[31]}}, fdInstr[31], fdInstr[7], fdInstr[30:25], fdInstr[11:8], 1'b0};
	assign immJ = {{11{fdInstr[31]}}, fdInstr[31], fdInstr[19:12], fdInstr[20], fdInstr[30:21],
		1'b0};

	// funct3 bit 0 turns BEQ into BNE
	assign takeBranch = isJal || (isBranch && ((cmpA == cmpB) ^ funct3[0]));
	assign branchTarget = fdPc + (isJal ? immJ : immB);

	// loads and stores use the adder for the address
	always_comb begin
		aluOp = rvPkg::aluAdd;
		if (op == rvPkg::opReg || op == rvPkg::opImm) begin
			case (funct3)
				3'b111: aluOp = rvPkg::aluAnd;
				3'b110: aluOp = rvPkg::aluOr;
				default: begin
					if (op == rvPkg::opReg && fdInstr[rvPkg::subBit]) begin
						aluOp = rvPkg::aluSub;
					end
				end
			endcase
		end
	end

	// a bubble replaces the decoded instruction with a NOP and clears its enables
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			deInstr <= rvPkg::nopInstr;
			deRegWrite <= 1'b0;
			deMemRead <= 1'b0;
			deMemWrite <= 1'b0;
			deIsLink <= 1'b0;
		end else begin
			deInstr <= deBubble ? rvPkg::nopInstr : fdInstr;
			deRegWrite <= !deBubble && (op == rvPkg::opReg || op == rvPkg::opImm ||
				op == rvPkg::opLoad || isJal);
			deMemRead <= !deBubble && (op == rvPkg::opLoad);
			deMemWrite <= !deBubble && (op == rvPkg::opStore);
			deIsLink <= !deBubble && isJal;
		end
	end

	always_ff @(posedge clk) begin
		deRs1Val <= rs1Val;
		deRs2Val <= rs2Val;
		deImm <= (op == rvPkg::opStore) ? immS : immI;
		deAluOp <= aluOp;
		deRd <= fdInstr[rvPkg::rdLsb +: rvPkg::regBits];
		deLink <= fdPc + 32'd4;
		deRs1 <= rs1;
		deRs2 <= rs2;
	end

endmodule

// File: design/hazardDetection.sv
// ################################################
// stall, flush and halt control for the pipeline
// purely combinational except the halted flag
// assumes branches resolve in decode and that the
// memory stage ALU result is forwarded there
// ################################################
`timescale 1ns/1ps
module hazardDetection (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [rvPkg::xlen-1:0] fdInstr,
	input  logic [rvPkg::xlen-1:0] deInstr,
	input  logic                   deRegWrite,
	input  logic                   deMemRead,
	input  logic [rvPkg::xlen-1:0] emInstr,
	input  logic                   emRegWrite,
	input  logic                   emMemRead,
	input  logic                   takeBranch,
	input  logic                   isControl,
	output logic                   pcEnable,
	output logic                   fdFlush,
	output logic                   fdHold,
	output logic                   deBubble,
	output logic                   redirect,
	output logic                   halted
);

	rvPkg::opcodeE fdOp;
	logic [rvPkg::regBits-1:0] rs1;
	logic [rvPkg::regBits-1:0] rs2;
	logic [rvPkg::regBits-1:0] deRd;
	logic [rvPkg::regBits-1:0] emRd;
	logic loadUse;
	logic aluBranch;
	logic loadBranch;
	logic stall;
	logic ecall;
	logic haltNow;

	// true when a nonzero destination is one of the sources read in decode
	function automatic logic readsReg(
		input logic [rvPkg::regBits-1:0] dst,
		input logic [rvPkg::regBits-1:0] a,
		input logic [rvPkg::regBits-1:0] b
	);
		return (dst != '0) && ((dst == a) || (dst == b));
	endfunction

	assign fdOp = rvPkg::opcodeE'(fdInstr[6:0]);

	// unused source fields are forced to x0 so they never match
	// JAL and ECALL read nothing, and only R, S and B formats read rs2
	assign rs1 = (fdOp == rvPkg::opJal || fdOp == rvPkg::opSystem) ? '0 :
		fdInstr[rvPkg::rs1Lsb +: rvPkg::regBits];
	assign rs2 = (fdOp == rvPkg::opReg || fdOp == rvPkg::opStore || fdOp == rvPkg::opBranch) ?
		fdInstr[rvPkg::rs2Lsb +: rvPkg::regBits] : '0;

	assign deRd = deInstr[rvPkg::rdLsb +: rvPkg::regBits];
	assign emRd = emInstr[rvPkg::rdLsb +: rvPkg::regBits];

	// load in execute feeding anything in decode
	assign loadUse = deMemRead && deRegWrite && readsReg(deRd, rs1, rs2);
	// the branch compares in decode, so even an ALU result one stage ahead is too late
	assign aluBranch = isControl && deRegWrite && !deMemRead && readsReg(deRd, rs1, rs2);
	// load data only exists after the memory stage, so the branch waits for writeback
	assign loadBranch = isControl && emMemRead && emRegWrite && readsReg(emRd, rs1, rs2);

	assign stall = loadUse || aluBranch || loadBranch;

	// a branch outcome computed from stale operands is ignored while stalled
	assign redirect = takeBranch && !stall;

	// ECALL stops fetch in the same cycle it reaches decode
	assign ecall = (fdOp == rvPkg::opSystem);
	assign haltNow = ecall || halted;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			halted <= 1'b0;
		end else if (ecall) begin
			halted <= 1'b1;
		end
	end

	// redirect keeps priority over the halt, as in the older core
	assign pcEnable = redirect || !(stall || haltNow);
	// after the halt every fetched word is dropped so nothing past ECALL runs
	assign fdFlush = redirect || stall || haltNow;
	assign fdHold = stall;
	assign deBubble = stall;

endmodule

// File: design/fetchStage.sv
// ################################################
// program counter, instruction memory and the
// fetch/decode register
// imemDepth must be a power of two, at most 256
// words, since the load port address is 8 bits
// ################################################
`timescale 1ns/1ps
module fetchStage #(
	parameter int imemDepth = 64
) (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    pcEnable,
	input  logic                    fdFlush,
	input  logic                    fdHold,
	input  logic [rvPkg::xlen-1:0]  branchTarget,
	input  logic                    redirect,
	input  logic                    imemWe,
	input  logic [7:0]              imemAddr,
	input  logic [rvPkg::xlen-1:0]  imemData,
	output logic [rvPkg::xlen-1:0]  fdInstr,
	output logic [rvPkg::xlen-1:0]  fdPc
);

	localparam int idxBits = $clog2(imemDepth);

	logic [rvPkg::xlen-1:0] pc;
	logic [rvPkg::xlen-1:0] imem [imemDepth];
	logic [rvPkg::xlen-1:0] fetched;

	// the load port is word addressed and normally used while the core is in reset
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr[idxBits-1:0]] <= imemData;
		end
	end

	// the PC is a byte address, so the word index drops the low two bits
	assign fetched = imem[pc[2 +: idxBits]];

	// a redirect wins over the plain increment
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= branchTarget;
		end else if (pcEnable) begin
			pc <= pc + 32'd4;
		end
	end

	// a hold keeps the stalled instruction in decode, and it takes priority over the flush
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			fdInstr <= rvPkg::nopInstr;
			fdPc <= '0;
		end else if (!fdHold) begin
			fdInstr <= fdFlush ? rvPkg::nopInstr : fetched;
			fdPc <= pc;
		end
	end

endmodule

// File: design/rvPkg.sv
// ################################################
// shared widths, field positions and encodings for
// the RV32I subset core
// only the opcodes the subset decodes are listed
// ################################################
package rvPkg;

	// machine word and register index widths
	localparam int xlen = 32;
	localparam int regBits = 5;

	// low bit of each instruction field
	localparam int rdLsb = 7;
	localparam int funct3Lsb = 12;
	localparam int rs1Lsb = 15;
	localparam int rs2Lsb = 20;

	// bit 30 tells SUB from ADD in the register format
	localparam int subBit = 30;

	// ADDI x0,x0,0 fills every flushed or bubbled slot
	localparam logic [xlen-1:0] nopInstr = 32'h0000_0013;

	// major opcodes of the supported instructions
	typedef enum logic [6:0] {
		opReg    = 7'b0110011,
		opImm    = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opSystem = 7'b1110011
	} opcodeE;

	typedef enum logic [1:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr
	} aluOpE;

endpackage
